/* filelist.f */
+incdir+verilog
verilog/dccm_pkg.sv
verilog/iccm_pkg.sv
verilog/ccm_bank.sv
verilog/dccm_mem.sv
verilog/iccm_mem.sv
verilog/ccm_mem.sv
tests/tb_clock.sv
tests/ccm_mem_tb.sv

/* tests/ccm_mem_tb.sv */
// CCM testbench with random and directed DCCM/ICCM traffic checked against reference arrays
`timescale 1ns/1ps
`include "ccm_cfg.svh"

module ccm_mem_tb;

   localparam int dccm_words = `DCCM_NUM_BANKS * `DCCM_BANK_DEPTH;
   localparam int iccm_words = `ICCM_NUM_BANKS * `ICCM_BANK_DEPTH;
   localparam int num_ops    = 200 * 2 + 20 * 3 + 100 * 2 + 40 * 3 + 30 * 3;
   localparam int max_cycles = 2 * num_ops + 100;

   // Word addresses with the bank in the two low bits
   typedef logic [`DCCM_BITS-3:0] dccm_waddr_t;
   typedef logic [`ICCM_BITS-3:0] iccm_waddr_t;

   typedef struct packed {
      dccm_pkg::dccm_word_t lo;
      dccm_pkg::dccm_word_t hi;
   } dccm_pair_t;

   typedef struct packed {
      logic [63:0]           data;
      iccm_pkg::iccm_dword_t ecc;
   } iccm_read_t;

   logic                  clk;
   logic                  reset;
   logic                  dccm_wren;
   logic                  dccm_rden;
   dccm_pkg::dccm_lane_t  dccm_wr_lo;
   dccm_pkg::dccm_lane_t  dccm_wr_hi;
   logic [`DCCM_BITS-1:0] dccm_rd_addr_lo;
   logic [`DCCM_BITS-1:0] dccm_rd_addr_hi;
   dccm_pkg::dccm_word_t  dccm_rd_data_lo;
   dccm_pkg::dccm_word_t  dccm_rd_data_hi;
   logic                  iccm_wren;
   logic                  iccm_rden;
   logic [`ICCM_BITS-1:1] iccm_rw_addr;
   iccm_pkg::iccm_size_e  iccm_wr_size;
   iccm_pkg::iccm_dword_t iccm_wr_data;
   logic [63:0]           iccm_rd_data;
   iccm_pkg::iccm_dword_t iccm_rd_data_ecc;

   dccm_pkg::dccm_word_t  dccm_ref [dccm_words];
   iccm_pkg::iccm_word_t  iccm_ref [iccm_words];
   dccm_waddr_t           dccm_written [$];

   dccm_pair_t  dccm_exp;
   dccm_pair_t  dccm_exp_q;
   iccm_read_t  iccm_exp;
   iccm_read_t  iccm_exp_q;
   logic        dccm_chk;
   logic        iccm_chk;
   logic        zero_window;    // From reset to the first read
   logic [31:0] rng_state;
   int          errors;
   int          cycles;

   tb_clock #(.period(100)) clock_i (.clk(clk));

   ccm_mem ccm_mem_inst (
      .clk              (clk),
      .reset            (reset),
      .dccm_wren        (dccm_wren),
      .dccm_rden        (dccm_rden),
      .dccm_wr_lo       (dccm_wr_lo),
      .dccm_wr_hi       (dccm_wr_hi),
      .dccm_rd_addr_lo  (dccm_rd_addr_lo),
      .dccm_rd_addr_hi  (dccm_rd_addr_hi),
      .dccm_rd_data_lo  (dccm_rd_data_lo),
      .dccm_rd_data_hi  (dccm_rd_data_hi),
      .iccm_wren        (iccm_wren),
      .iccm_rden        (iccm_rden),
      .iccm_rw_addr     (iccm_rw_addr),
      .iccm_wr_size     (iccm_wr_size),
      .iccm_wr_data     (iccm_wr_data),
      .iccm_rd_data     (iccm_rd_data),
      .iccm_rd_data_ecc (iccm_rd_data_ecc)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [`CCM_DATA_WIDTH+`CCM_ECC_WIDTH-1:0] rand_word();
      logic [31:0] data;
      logic [31:0] ecc;
      data = next_rand();
      ecc  = next_rand();
      return {data, ecc[`CCM_ECC_WIDTH-1:0]};
   endfunction

   function automatic dccm_waddr_t pick_written();
      return dccm_written[next_rand() % dccm_written.size()];
   endfunction

   task automatic report_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] got);
      errors++;
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
   endtask

   // One operation per cycle and strobes drop unless set again
   task automatic next_cycle();
      @(negedge clk);
      dccm_wren = 1'b0;
      dccm_rden = 1'b0;
      iccm_wren = 1'b0;
      iccm_rden = 1'b0;
   endtask

   task automatic dccm_write(input dccm_waddr_t lo_wa, input dccm_waddr_t hi_wa);
      dccm_pkg::dccm_word_t lo_w;
      dccm_pkg::dccm_word_t hi_w;
      lo_w = rand_word();
      hi_w = rand_word();
      next_cycle();
      dccm_wren       = 1'b1;
      dccm_wr_lo.addr = {lo_wa, 2'(next_rand())};
      dccm_wr_hi.addr = {hi_wa, 2'(next_rand())};
      dccm_wr_lo.word = lo_w;
      dccm_wr_hi.word = hi_w;
      if (hi_wa[1:0] != lo_wa[1:0]) begin   // Same bank keeps the hi lane out
         dccm_ref[hi_wa] = hi_w;
         dccm_written.push_back(hi_wa);
      end
      dccm_ref[lo_wa] = lo_w;
      dccm_written.push_back(lo_wa);
   endtask

   task automatic dccm_read(input dccm_waddr_t lo_wa, input dccm_waddr_t hi_wa);
      next_cycle();
      dccm_rden       = 1'b1;
      dccm_rd_addr_lo = {lo_wa, 2'(next_rand())};
      dccm_rd_addr_hi = {hi_wa, 2'(next_rand())};
      dccm_exp.lo     = dccm_ref[lo_wa];
      dccm_exp.hi     = (hi_wa[1:0] == lo_wa[1:0]) ? dccm_ref[lo_wa] : dccm_ref[hi_wa];
   endtask

   task automatic iccm_write(input iccm_waddr_t wa, input iccm_pkg::iccm_size_e size);
      iccm_pkg::iccm_dword_t wd;
      iccm_waddr_t           wa1;
      wd.lo = rand_word();
      wd.hi = rand_word();
      wa1   = wa + 1'b1;
      next_cycle();
      iccm_wren    = 1'b1;
      iccm_rw_addr = {wa, 1'b0};
      iccm_wr_size = size;
      iccm_wr_data = wd;
      iccm_ref[wa] = wd.lo;
      if (size == iccm_pkg::size_double) begin
         iccm_ref[wa1] = wd.hi;
      end
   endtask

   task automatic iccm_read(input iccm_waddr_t wa, input logic half);
      iccm_waddr_t wa1;
      iccm_waddr_t wa2;
      wa1 = wa + 1'b1;
      wa2 = wa + 2'd2;
      next_cycle();
      iccm_rden       = 1'b1;
      iccm_rw_addr    = {wa, half};
      iccm_exp.ecc.hi = iccm_ref[wa1];
      iccm_exp.ecc.lo = iccm_ref[wa];
      if (half) begin
         iccm_exp.data = {iccm_ref[wa2].data[15:0], iccm_ref[wa1].data,
                          iccm_ref[wa].data[31:16]};
      end else begin
         iccm_exp.data = {iccm_ref[wa1].data, iccm_ref[wa].data};
      end
   endtask

   // ********************
   // Checks
   // ********************

   always @(posedge clk) begin
      dccm_chk <= dccm_rden && !reset;
      iccm_chk <= iccm_rden && !reset;
      if (dccm_rden) begin
         dccm_exp_q <= dccm_exp;
      end
      if (iccm_rden) begin
         iccm_exp_q <= iccm_exp;
      end
      if (reset) begin
         zero_window <= 1'b1;
      end else if (dccm_rden || iccm_rden) begin
         zero_window <= 1'b0;
      end
   end

   // Sampled mid-cycle one edge after the read
   a_zero_dccm_lo: assert property (@(negedge clk) zero_window |-> dccm_rd_data_lo == '0)
      else report_mismatch("dccm_rd_data_lo", '0, dccm_rd_data_lo);
   a_zero_dccm_hi: assert property (@(negedge clk) zero_window |-> dccm_rd_data_hi == '0)
      else report_mismatch("dccm_rd_data_hi", '0, dccm_rd_data_hi);
   a_zero_iccm: assert property (@(negedge clk) zero_window |-> iccm_rd_data == '0)
      else report_mismatch("iccm_rd_data", '0, iccm_rd_data);
   a_zero_iccm_ecc: assert property (@(negedge clk) zero_window |-> iccm_rd_data_ecc == '0)
      else report_mismatch("iccm_rd_data_ecc", '0, iccm_rd_data_ecc);

   a_dccm_lo: assert property (@(negedge clk) dccm_chk |-> dccm_rd_data_lo == dccm_exp_q.lo)
      else report_mismatch("dccm_rd_data_lo", dccm_exp_q.lo, dccm_rd_data_lo);
   a_dccm_hi: assert property (@(negedge clk) dccm_chk |-> dccm_rd_data_hi == dccm_exp_q.hi)
      else report_mismatch("dccm_rd_data_hi", dccm_exp_q.hi, dccm_rd_data_hi);
   a_iccm: assert property (@(negedge clk) iccm_chk |-> iccm_rd_data == iccm_exp_q.data)
      else report_mismatch("iccm_rd_data", iccm_exp_q.data, iccm_rd_data);
   a_iccm_ecc: assert property (@(negedge clk) iccm_chk |-> iccm_rd_data_ecc == iccm_exp_q.ecc)
      else report_mismatch("iccm_rd_data_ecc", iccm_exp_q.ecc, iccm_rd_data_ecc);

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run timed out after %0d cycles with %0d errors", cycles, errors);
      $display("** FAIL **");
      $finish;
   end

   // ********************
   // Stimulus
   // ********************

   initial begin
      dccm_waddr_t a;
      dccm_waddr_t b;
      iccm_waddr_t wa;
      rng_state       = 32'hdef6_5699;
      errors          = 0;
      reset           = 1'b1;
      dccm_wren       = 1'b0;
      dccm_rden       = 1'b0;
      dccm_wr_lo      = '0;
      dccm_wr_hi      = '0;
      dccm_rd_addr_lo = '0;
      dccm_rd_addr_hi = '0;
      iccm_wren       = 1'b0;
      iccm_rden       = 1'b0;
      iccm_rw_addr    = '0;
      iccm_wr_size    = iccm_pkg::size_byte;
      iccm_wr_data    = '0;
      zero_window     = 1'b0;
      dccm_chk        = 1'b0;
      iccm_chk        = 1'b0;
      dccm_exp        = '0;
      iccm_exp        = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      for (int n = 0; n < 200; n++) begin
         dccm_write(dccm_waddr_t'(next_rand()), dccm_waddr_t'(next_rand()));
         dccm_read(pick_written(), pick_written());
      end

      // Both lanes in one bank so lo wins
      for (int n = 0; n < 20; n++) begin
         b      = pick_written();
         a      = dccm_waddr_t'(next_rand());
         a[1:0] = b[1:0];
         dccm_write(a, b);
         dccm_read(b, a);
         dccm_read(a, b);
      end

      for (int n = 0; n < 100; n++) begin
         wa      = iccm_waddr_t'(next_rand());
         wa[1:0] = 2'(n);   // Every bank including the bank 3 index wrap
         iccm_write(wa, iccm_pkg::size_double);
         iccm_read(wa, 1'b0);
      end

      // Odd halfword start needs three written words
      for (int n = 0; n < 40; n++) begin
         wa = iccm_waddr_t'(next_rand());
         iccm_write(wa, iccm_pkg::size_double);
         iccm_write(wa + 2'd2, iccm_pkg::size_double);
         iccm_read(wa, 1'b1);
      end

      for (int n = 0; n < 30; n++) begin
         wa = iccm_waddr_t'(next_rand());
         iccm_write(wa, iccm_pkg::size_double);
         iccm_write(wa, iccm_pkg::iccm_size_e'(n % 3));   // byte, half or word
         iccm_read(wa, 1'b0);
      end

      next_cycle();
      next_cycle();
      $display("Checks done after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* tests/tb_clock.sv */
// Testbench clock generator, free running from time zero
`timescale 1ns/1ps

module tb_clock #(
   parameter int period = 100   // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

/* verilog/ccm_bank.sv */
// CCM bank: single-port synchronous RAM with a registered read, generic over the word type
`timescale 1ns/1ps

module ccm_bank #(
   parameter type word_t = logic [38:0],
   parameter int  depth  = 256
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     we,
   input  logic                     re,
   input  logic [$clog2(depth)-1:0] index,
   input  word_t                    wdata,
   output word_t                    rdata
);

   word_t mem [depth];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[index] <= wdata;
      end
   end

   // Read data holds until the next re
   always_ff @(posedge clk) begin
      if (reset) begin
         rdata <= '0;
      end else if (re) begin
         rdata <= mem[index];
      end
   end

   // Single port, one access per cycle
   a_bank_one_access: assert property (
      @(posedge clk) disable iff (reset) we |-> !re
   );

endmodule

/* verilog/ccm_cfg.svh */
// CCM sizing: address widths, bank counts and stored word layout for DCCM and ICCM
`ifndef CCM_CFG_SVH
`define CCM_CFG_SVH

// ********************
// Stored word
// ********************

`define CCM_DATA_WIDTH   32
`define CCM_ECC_WIDTH    7    // Check bits, generated outside

// ********************
// DCCM, byte addressed
// ********************

`define DCCM_BITS        12   // 4 KB
`define DCCM_NUM_BANKS   4
`define DCCM_BANK_DEPTH  256

// ********************
// ICCM, halfword addressed
// ********************

// Port carries ICCM_BITS-1 down to 1
`define ICCM_BITS        12   // 4 KB
`define ICCM_NUM_BANKS   4
`define ICCM_BANK_DEPTH  256

`endif

/* verilog/ccm_mem.sv */
// CCM top: data and instruction closely coupled memories side by side
`timescale 1ns/1ps
`include "ccm_cfg.svh"

module ccm_mem (
   input  logic                   clk,
   input  logic                   reset,

   // ********************
   // DCCM
   // ********************
   input  logic                   dccm_wren,
   input  logic                   dccm_rden,
   input  dccm_pkg::dccm_lane_t   dccm_wr_lo,
   input  dccm_pkg::dccm_lane_t   dccm_wr_hi,
   input  logic [`DCCM_BITS-1:0]  dccm_rd_addr_lo,
   input  logic [`DCCM_BITS-1:0]  dccm_rd_addr_hi,
   output dccm_pkg::dccm_word_t   dccm_rd_data_lo,
   output dccm_pkg::dccm_word_t   dccm_rd_data_hi,

   // ********************
   // ICCM
   // ********************
   input  logic                   iccm_wren,
   input  logic                   iccm_rden,
   input  logic [`ICCM_BITS-1:1]  iccm_rw_addr,
   input  iccm_pkg::iccm_size_e   iccm_wr_size,
   input  iccm_pkg::iccm_dword_t  iccm_wr_data,
   output logic [63:0]            iccm_rd_data,
   output iccm_pkg::iccm_dword_t  iccm_rd_data_ecc
);

   dccm_mem dccm_mem_i (
      .clk             (clk),
      .reset           (reset),
      .dccm_wren       (dccm_wren),
      .dccm_rden       (dccm_rden),
      .dccm_wr_lo      (dccm_wr_lo),
      .dccm_wr_hi      (dccm_wr_hi),
      .dccm_rd_addr_lo (dccm_rd_addr_lo),
      .dccm_rd_addr_hi (dccm_rd_addr_hi),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi)
   );

   iccm_mem iccm_mem_i (
      .clk              (clk),
      .reset            (reset),
      .iccm_wren        (iccm_wren),
      .iccm_rden        (iccm_rden),
      .iccm_rw_addr     (iccm_rw_addr),
      .iccm_wr_size     (iccm_wr_size),
      .iccm_wr_data     (iccm_wr_data),
      .iccm_rd_data     (iccm_rd_data),
      .iccm_rd_data_ecc (iccm_rd_data_ecc)
   );

endmodule

/* verilog/dccm_mem.sv */
// DCCM: four-bank data memory with lo/hi lane decode and read data steering
`timescale 1ns/1ps
`include "ccm_cfg.svh"

module dccm_mem (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dccm_wren,
   input  logic                  dccm_rden,
   input  dccm_pkg::dccm_lane_t  dccm_wr_lo,
   input  dccm_pkg::dccm_lane_t  dccm_wr_hi,
   input  logic [`DCCM_BITS-1:0] dccm_rd_addr_lo,
   input  logic [`DCCM_BITS-1:0] dccm_rd_addr_hi,
   output dccm_pkg::dccm_word_t  dccm_rd_data_lo,
   output dccm_pkg::dccm_word_t  dccm_rd_data_hi
);

   localparam int bank_bits  = $clog2(`DCCM_NUM_BANKS);
   localparam int index_bits = $clog2(`DCCM_BANK_DEPTH);
   localparam int bank_lo    = $clog2(`CCM_DATA_WIDTH / 8);  // Byte in word
   localparam int index_lo   = bank_lo + bank_bits;

   logic [bank_bits-1:0]  wr_lo_bank;
   logic [bank_bits-1:0]  wr_hi_bank;
   logic [bank_bits-1:0]  rd_lo_bank;
   logic [bank_bits-1:0]  rd_hi_bank;
   logic [index_bits-1:0] wr_lo_index;
   logic [index_bits-1:0] wr_hi_index;
   logic [index_bits-1:0] rd_lo_index;
   logic [index_bits-1:0] rd_hi_index;
   logic [bank_bits-1:0]  rd_lo_bank_q;
   logic [bank_bits-1:0]  rd_hi_bank_q;

   dccm_pkg::dccm_word_t  bank_rdata [`DCCM_NUM_BANKS];

   // ********************
   // Lane decode
   // ********************

   assign wr_lo_bank  = dccm_wr_lo.addr[bank_lo +: bank_bits];
   assign wr_hi_bank  = dccm_wr_hi.addr[bank_lo +: bank_bits];
   assign rd_lo_bank  = dccm_rd_addr_lo[bank_lo +: bank_bits];
   assign rd_hi_bank  = dccm_rd_addr_hi[bank_lo +: bank_bits];
   assign wr_lo_index = dccm_wr_lo.addr[index_lo +: index_bits];
   assign wr_hi_index = dccm_wr_hi.addr[index_lo +: index_bits];
   assign rd_lo_index = dccm_rd_addr_lo[index_lo +: index_bits];
   assign rd_hi_index = dccm_rd_addr_hi[index_lo +: index_bits];

   for (genvar k = 0; k < `DCCM_NUM_BANKS; k++) begin : g_bank
      logic                  wr_lo_hit;
      logic                  wr_hi_hit;
      logic                  rd_lo_hit;
      logic                  rd_hi_hit;
      logic [index_bits-1:0] bank_index;

      assign wr_lo_hit = dccm_wren && (wr_lo_bank == bank_bits'(k));
      assign wr_hi_hit = dccm_wren && (wr_hi_bank == bank_bits'(k)) && !wr_lo_hit;  // lo wins
      assign rd_lo_hit = dccm_rden && (rd_lo_bank == bank_bits'(k));
      assign rd_hi_hit = dccm_rden && (rd_hi_bank == bank_bits'(k));

      // Write address first, then lo read before hi read
      assign bank_index = wr_lo_hit ? wr_lo_index :
                          wr_hi_hit ? wr_hi_index :
                          rd_lo_hit ? rd_lo_index : rd_hi_index;

      ccm_bank #(
         .word_t (dccm_pkg::dccm_word_t),
         .depth  (`DCCM_BANK_DEPTH)
      ) bank_i (
         .clk   (clk),
         .reset (reset),
         .we    (wr_lo_hit || wr_hi_hit),
         .re    (rd_lo_hit || rd_hi_hit),
         .index (bank_index),
         .wdata (wr_lo_hit ? dccm_wr_lo.word : dccm_wr_hi.word),
         .rdata (bank_rdata[k])
      );
   end

   // ********************
   // Read steering
   // ********************

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_lo_bank_q <= '0;
         rd_hi_bank_q <= '0;
      end else if (dccm_rden) begin
         rd_lo_bank_q <= rd_lo_bank;
         rd_hi_bank_q <= rd_hi_bank;
      end
   end

   assign dccm_rd_data_lo = bank_rdata[rd_lo_bank_q];
   assign dccm_rd_data_hi = bank_rdata[rd_hi_bank_q];  // Same bank gives the lo word

   a_dccm_rw_excl: assert property (
      @(posedge clk) disable iff (reset) !(dccm_wren && dccm_rden)
   );

endmodule

/* verilog/dccm_pkg.sv */
// DCCM types: stored data word and write lane
`include "ccm_cfg.svh"

package dccm_pkg;

   // One bank entry, data with its check bits
   typedef struct packed {
      logic [`CCM_DATA_WIDTH-1:0] data;
      logic [`CCM_ECC_WIDTH-1:0]  ecc;
   } dccm_word_t;

   // Write lane, byte address plus word
   typedef struct packed {
      logic [`DCCM_BITS-1:0] addr;
      dccm_word_t            word;
   } dccm_lane_t;

endpackage

/* verilog/iccm_mem.sv */
// ICCM: four-bank instruction memory with double-word writes and halfword-aligned 64-bit reads
`timescale 1ns/1ps
`include "ccm_cfg.svh"

module iccm_mem (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   iccm_wren,
   input  logic                   iccm_rden,
   input  logic [`ICCM_BITS-1:1]  iccm_rw_addr,
   input  iccm_pkg::iccm_size_e   iccm_wr_size,
   input  iccm_pkg::iccm_dword_t  iccm_wr_data,
   output logic [63:0]            iccm_rd_data,
   output iccm_pkg::iccm_dword_t  iccm_rd_data_ecc
);

   localparam int bank_bits  = $clog2(`ICCM_NUM_BANKS);
   localparam int index_bits = $clog2(`ICCM_BANK_DEPTH);
   localparam int bank_lo    = $clog2(`CCM_DATA_WIDTH / 8);
   localparam int index_lo   = bank_lo + bank_bits;

   logic [bank_bits-1:0]  addr_bank;
   logic [index_bits-1:0] addr_index;
   logic                  wr_double;
   logic [bank_bits-1:0]  rd_bank_q;
   logic                  rd_half_q;     // Address bit 1 of the last read

   iccm_pkg::iccm_word_t  bank_rdata [`ICCM_NUM_BANKS];
   iccm_pkg::iccm_word_t  w0;
   iccm_pkg::iccm_word_t  w1;
   iccm_pkg::iccm_word_t  w2;

   assign addr_bank  = iccm_rw_addr[bank_lo +: bank_bits];
   assign addr_index = iccm_rw_addr[index_lo +: index_bits];
   assign wr_double  = (iccm_wr_size == iccm_pkg::size_double);

   // ********************
   // Per-bank address and enables
   // ********************

   for (genvar k = 0; k < `ICCM_NUM_BANKS; k++) begin : g_bank
      logic [bank_bits-1:0]  offset;
      logic [index_bits-1:0] bank_index;
      logic                  bank_we;
      logic                  bank_re;

      assign offset = bank_bits'(k) - addr_bank;

      // Banks below b belong to the next row
      assign bank_index = (bank_bits'(k) < addr_bank) ? addr_index + index_bits'(1)
                                                      : addr_index;

      assign bank_we = iccm_wren &&
                       ((offset == '0) || (wr_double && (offset == bank_bits'(1))));
      assign bank_re = iccm_rden && (offset <= bank_bits'(2));   // w0, w1, w2

      ccm_bank #(
         .word_t (iccm_pkg::iccm_word_t),
         .depth  (`ICCM_BANK_DEPTH)
      ) bank_i (
         .clk   (clk),
         .reset (reset),
         .we    (bank_we),
         .re    (bank_re),
         .index (bank_index),
         .wdata ((offset == '0) ? iccm_wr_data.lo : iccm_wr_data.hi),
         .rdata (bank_rdata[k])
      );
   end

   // ********************
   // Read rotate and align
   // ********************

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_bank_q <= '0;
         rd_half_q <= 1'b0;
      end else if (iccm_rden) begin
         rd_bank_q <= addr_bank;
         rd_half_q <= iccm_rw_addr[1];
      end
   end

   assign w0 = bank_rdata[rd_bank_q];
   assign w1 = bank_rdata[rd_bank_q + bank_bits'(1)];
   assign w2 = bank_rdata[rd_bank_q + bank_bits'(2)];

   assign iccm_rd_data_ecc = '{hi: w1, lo: w0};

   // Odd halfword start shifts in the low half of w2
   assign iccm_rd_data = rd_half_q ? {w2.data[15:0], w1.data, w0.data[31:16]}
                                   : {w1.data, w0.data};

   a_iccm_rw_excl: assert property (
      @(posedge clk) disable iff (reset) !(iccm_wren && iccm_rden)
   );

   // Double writes start on a word boundary
   a_iccm_dbl_align: assert property (
      @(posedge clk) disable iff (reset) (iccm_wren && wr_double) |-> !iccm_rw_addr[1]
   );

endmodule

/* verilog/iccm_pkg.sv */
// ICCM types: stored word, double word and write size
`include "ccm_cfg.svh"

package iccm_pkg;

   // One bank entry
   typedef struct packed {
      logic [`CCM_DATA_WIDTH-1:0] data;
      logic [`CCM_ECC_WIDTH-1:0]  ecc;
   } iccm_word_t;

   // Two consecutive words, hi at the higher address
   typedef struct packed {
      iccm_word_t hi;
      iccm_word_t lo;
   } iccm_dword_t;

   // Write size, only size_double spans two banks
   typedef enum logic [1:0] {
      size_byte   = 2'd0,
      size_half   = 2'd1,
      size_word   = 2'd2,
      size_double = 2'd3
   } iccm_size_e;

endpackage
